/* logic/mips_branch_pkg.sv */
package mips_branch_pkg;

    //==========================================================================
    // primary opcodes, bits 31:26 of the instruction word
    //==========================================================================

    localparam logic [5:0] op_special = 6'b000000; // jr and jalr live under funct
    localparam logic [5:0] op_regimm  = 6'b000001; // compare-with-zero group, keyed by rt
    localparam logic [5:0] op_j       = 6'b000010;
    localparam logic [5:0] op_jal     = 6'b000011;
    localparam logic [5:0] op_beq     = 6'b000100;
    localparam logic [5:0] op_bne     = 6'b000101;
    localparam logic [5:0] op_blez    = 6'b000110;
    localparam logic [5:0] op_bgtz    = 6'b000111;

    // regimm sub-codes carried in the rt field
    localparam logic [4:0] rt_bltz    = 5'b00000;
    localparam logic [4:0] rt_bgez    = 5'b00001;
    localparam logic [4:0] rt_bltzal  = 5'b10000; // bit 4 marks the linking forms
    localparam logic [4:0] rt_bgezal  = 5'b10001;

    // special group function codes
    localparam logic [5:0] funct_jr   = 6'b001000;
    localparam logic [5:0] funct_jalr = 6'b001001;

    //==========================================================================
    // control kinds handed from decode to resolve
    //==========================================================================

    localparam int cf_kind_w = 4;

    localparam logic [cf_kind_w-1:0] cf_none = 4'd0; // sequential flow
    localparam logic [cf_kind_w-1:0] cf_beq  = 4'd1;
    localparam logic [cf_kind_w-1:0] cf_bne  = 4'd2;
    localparam logic [cf_kind_w-1:0] cf_blez = 4'd3;
    localparam logic [cf_kind_w-1:0] cf_bgtz = 4'd4;
    localparam logic [cf_kind_w-1:0] cf_bltz = 4'd5; // also bltzal
    localparam logic [cf_kind_w-1:0] cf_bgez = 4'd6; // also bgezal
    localparam logic [cf_kind_w-1:0] cf_j    = 4'd7; // also jal
    localparam logic [cf_kind_w-1:0] cf_jr   = 4'd8; // also jalr

    localparam logic [4:0] link_reg_ra = 5'd31;

    // one instruction word seen through the three MIPS encodings
    typedef union packed {
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i_fmt;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] index;
        } j_fmt;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [4:0]  rd;
            logic [4:0]  shamt;
            logic [5:0]  funct;
        } r_fmt;
    } mips_instr_u;

endpackage

/* logic/branch_decode.sv */
`timescale 1ns/1ps

module branch_decode
    import mips_branch_pkg::*;
(
    input  mips_instr_u           instruction,
    output logic [cf_kind_w-1:0]  cf_kind,
    output logic [31:0]           imm_offset,
    output logic [25:0]           jump_index,
    output logic                  link_en,
    output logic [4:0]            link_dest
);

    logic [5:0]  opcode;
    logic [4:0]  regimm_code;
    logic [5:0]  funct;
    logic [15:0] imm;

    assign opcode      = instruction.i_fmt.opcode;
    assign regimm_code = instruction.i_fmt.rt;    // rt selects the regimm variant
    assign funct       = instruction.r_fmt.funct;
    assign imm         = instruction.i_fmt.imm;

    //==========================================================================
    // offset and index fields
    //==========================================================================

    // word offset, sign-extended and turned into a byte offset
    assign imm_offset = {{14{imm[15]}}, imm, 2'b00};

    assign jump_index = instruction.j_fmt.index;

    //==========================================================================
    // control kind and link selection
    //==========================================================================

    always_comb begin
        cf_kind   = cf_none;
        link_en   = 1'b0;
        link_dest = link_reg_ra;
        case (opcode)
            op_special: begin
                case (funct)
                    funct_jr: begin
                        cf_kind = cf_jr;
                    end
                    funct_jalr: begin
                        cf_kind   = cf_jr;
                        link_en   = 1'b1;
                        link_dest = instruction.r_fmt.rd; // jalr names its own link register
                    end
                    default: begin
                        cf_kind = cf_none;                // ordinary alu ops, nop included
                    end
                endcase
            end
            op_regimm: begin
                case (regimm_code)
                    rt_bltz: begin
                        cf_kind = cf_bltz;
                    end
                    rt_bgez: begin
                        cf_kind = cf_bgez;
                    end
                    rt_bltzal: begin
                        cf_kind = cf_bltz;
                        link_en = 1'b1;
                    end
                    rt_bgezal: begin
                        cf_kind = cf_bgez;
                        link_en = 1'b1;
                    end
                    default: begin
                        cf_kind = cf_none;                // unsupported regimm encodings
                    end
                endcase
            end
            op_j: begin
                cf_kind = cf_j;
            end
            op_jal: begin
                cf_kind = cf_j;
                link_en = 1'b1;
            end
            op_beq: begin
                cf_kind = cf_beq;
            end
            op_bne: begin
                cf_kind = cf_bne;
            end
            op_blez: begin
                cf_kind = cf_blez;
            end
            op_bgtz: begin
                cf_kind = cf_bgtz;
            end
            default: begin
                cf_kind = cf_none;
            end
        endcase
    end

    // a link write is only legal for an instruction that changes the flow
    no_link_without_kind: assert final (!(cf_kind == cf_none && link_en))
        else $error("link_en raised for a non-control instruction");

endmodule

/* logic/branch_resolve.sv */
`timescale 1ns/1ps

module branch_resolve
    import mips_branch_pkg::*;
(
    input  logic [cf_kind_w-1:0]  cf_kind,
    input  logic [31:0]           imm_offset,
    input  logic [25:0]           jump_index,
    input  logic [31:0]           rs_value,
    input  logic [31:0]           rt_value,
    input  logic [31:0]           decode_pc,
    output logic                  redirect,
    output logic [31:0]           redirect_target
);

    logic        eq;
    logic        sign;
    logic        zero;
    logic        taken;
    logic [31:0] pc_plus4;
    logic [31:0] branch_target;
    logic [31:0] jump_target;

    //==========================================================================
    // operand flags
    //==========================================================================

    assign eq   = (rs_value == rt_value);
    assign sign = rs_value[31];           // two's complement negative
    assign zero = (rs_value == 32'd0);

    //==========================================================================
    // candidate targets
    //==========================================================================

    // both relative and region targets are taken from the delay-slot address
    assign pc_plus4      = decode_pc + 32'd4;
    assign branch_target = pc_plus4 + imm_offset;
    assign jump_target   = {pc_plus4[31:28], jump_index, 2'b00};

    //==========================================================================
    // taken decision and target select
    //==========================================================================

    always_comb begin
        taken           = 1'b0;
        redirect_target = branch_target;
        case (cf_kind)
            cf_beq: begin
                taken = eq;
            end
            cf_bne: begin
                taken = !eq;
            end
            cf_blez: begin
                taken = sign | zero;
            end
            cf_bgtz: begin
                taken = !(sign | zero);
            end
            cf_bltz: begin
                taken = sign;
            end
            cf_bgez: begin
                taken = !sign;
            end
            cf_j: begin
                taken           = 1'b1;
                redirect_target = jump_target;
            end
            cf_jr: begin
                taken           = 1'b1;
                redirect_target = rs_value;   // register target, no alignment check
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

    assign redirect = taken;

endmodule

/* logic/pc_sequencer.sv */
`timescale 1ns/1ps

module pc_sequencer #(
    parameter logic [31:0] reset_vector = 32'hbfc00000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        clk_enable,
    input  logic        redirect,
    input  logic [31:0] redirect_target,
    input  logic        link_en,
    input  logic [4:0]  link_dest,
    output logic [31:0] fetch_pc,
    output logic [31:0] decode_pc,
    output logic        link_write,
    output logic [4:0]  link_reg,
    output logic [31:0] link_value
);

    logic [31:0] seq_pc;
    logic [31:0] next_fetch_pc;

    //==========================================================================
    // fetch address selection
    //==========================================================================

    // while a control instruction sits in decode, fetch_pc already holds its
    // delay slot, so the redirect lands on the fetch after that
    assign seq_pc        = fetch_pc + 32'd4;
    assign next_fetch_pc = redirect ? redirect_target : seq_pc;

    //==========================================================================
    // address registers
    //==========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc   <= reset_vector;
            decode_pc  <= reset_vector - 32'd4; // nothing real in decode yet
            link_write <= 1'b0;
        end else begin
            link_write <= clk_enable & link_en;  // one pulse per consumed link instruction
            if (clk_enable) begin
                fetch_pc  <= next_fetch_pc;
                decode_pc <= fetch_pc;
            end
        end
    end

    // return address and destination, qualified downstream by link_write
    always_ff @(posedge clk) begin
        if (clk_enable) begin
            link_reg   <= link_dest;
            link_value <= decode_pc + 32'd8;     // skips the delay slot
        end
    end

    //==========================================================================
    // checks
    //==========================================================================

    fetch_pc_holds_on_stall: assert property (
        @(posedge clk) disable iff (reset)
        !clk_enable |=> $stable(fetch_pc)
    ) else $error("fetch_pc moved across a stalled edge");

    // back-to-back pulses need two consecutive enabled edges behind them
    link_pulse_needs_enable: assert property (
        @(posedge clk) disable iff (reset)
        (link_write && $past(link_write)) |-> ($past(clk_enable) && $past(clk_enable, 2))
    ) else $error("link_write repeated without enabled edges");

endmodule

/* logic/branch_unit_top.sv */
`timescale 1ns/1ps

module branch_unit_top
    import mips_branch_pkg::*;
#(
    parameter logic [31:0] reset_vector = 32'hbfc00000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        clk_enable,
    input  mips_instr_u instruction,
    input  logic [31:0] rs_value,
    input  logic [31:0] rt_value,
    output logic [31:0] fetch_pc,
    output logic        link_write,
    output logic [4:0]  link_reg,
    output logic [31:0] link_value
);

    logic [cf_kind_w-1:0] cf_kind;
    logic [31:0]          imm_offset;
    logic [25:0]          jump_index;
    logic                 link_en;
    logic [4:0]           link_dest;
    logic                 redirect;
    logic [31:0]          redirect_target;
    logic [31:0]          decode_pc;

    branch_decode decode_inst (
        .instruction (instruction),
        .cf_kind     (cf_kind),
        .imm_offset  (imm_offset),
        .jump_index  (jump_index),
        .link_en     (link_en),
        .link_dest   (link_dest)
    );

    branch_resolve resolve_inst (
        .cf_kind         (cf_kind),
        .imm_offset      (imm_offset),
        .jump_index      (jump_index),
        .rs_value        (rs_value),
        .rt_value        (rt_value),
        .decode_pc       (decode_pc),       // address of the instruction being resolved
        .redirect        (redirect),
        .redirect_target (redirect_target)
    );

    pc_sequencer #(
        .reset_vector (reset_vector)
    ) sequencer_inst (
        .clk             (clk),
        .reset           (reset),
        .clk_enable      (clk_enable),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .link_en         (link_en),
        .link_dest       (link_dest),
        .fetch_pc        (fetch_pc),
        .decode_pc       (decode_pc),
        .link_write      (link_write),
        .link_reg        (link_reg),
        .link_value      (link_value)
    );

endmodule

/* bench/branch_ref.svh */
`ifndef BRANCH_REF_SVH
`define BRANCH_REF_SVH

//============================================================================
// reference rules for the branch unit, written from the MIPS definitions
//============================================================================

// 32-bit fibonacci lfsr with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
endfunction

function automatic logic branch_taken(
    input logic [31:0] word,
    input logic [31:0] rs,
    input logic [31:0] rt
);
    logic [5:0] op;
    logic [4:0] code;
    logic [5:0] fn;
    op   = word[31:26];
    code = word[20:16];
    fn   = word[5:0];
    case (op)
        op_special: return (fn == funct_jr) || (fn == funct_jalr);
        op_regimm: begin
            if (code == rt_bltz || code == rt_bltzal) return $signed(rs) < 0;
            if (code == rt_bgez || code == rt_bgezal) return $signed(rs) >= 0;
            return 1'b0;                              // reserved regimm codes fall through
        end
        op_j, op_jal: return 1'b1;
        op_beq:  return rs == rt;
        op_bne:  return rs != rt;
        op_blez: return $signed(rs) <= 0;
        op_bgtz: return $signed(rs) > 0;
        default: return 1'b0;
    endcase
endfunction

function automatic logic [31:0] branch_target(
    input logic [31:0] word,
    input logic [31:0] rs,
    input logic [31:0] pc
);
    logic [31:0] slot_pc;
    logic [31:0] offset;
    slot_pc = pc + 32'd4;
    offset  = {{16{word[15]}}, word[15:0]} << 2;
    if (word[31:26] == op_j || word[31:26] == op_jal) return {slot_pc[31:28], word[25:0], 2'b00};
    if (word[31:26] == op_special) return rs;
    return slot_pc + offset;
endfunction

function automatic logic link_expected(input logic [31:0] word);
    if (word[31:26] == op_jal) return 1'b1;
    if (word[31:26] == op_special) return word[5:0] == funct_jalr;
    if (word[31:26] == op_regimm) return word[20:16] == rt_bltzal || word[20:16] == rt_bgezal;
    return 1'b0;
endfunction

function automatic logic [4:0] link_register(input logic [31:0] word);
    return (word[31:26] == op_special) ? word[15:11] : 5'd31;  // jalr names rd
endfunction

`endif

/* bench/branch_unit_tb.sv */
`timescale 1ns/1ps

module branch_unit_tb
    import mips_branch_pkg::*;
();

    `include "branch_ref.svh"

    localparam logic [31:0] dut_reset_vector = 32'hbfc00000;
    localparam int num_instr   = 2000;
    localparam int cycle_limit = num_instr + num_instr / 4;

    logic        clk;
    logic        reset;
    logic        clk_enable;
    logic [31:0] instr_word;
    logic [31:0] rs_value;
    logic [31:0] rt_value;
    logic [31:0] fetch_pc;
    logic        link_write;
    logic [4:0]  link_reg;
    logic [31:0] link_value;

    logic [31:0] lfsr_state;
    int          mismatch_count = 0;
    int          timeout_count = 0;
    int          cycle_count = 0;

    logic [31:0] model_fetch_pc;
    logic [31:0] model_decode_pc;
    logic        exp_link_write;
    logic [4:0]  exp_link_reg;
    logic [31:0] exp_link_value;
    logic        consumed_sequential;

    branch_unit_top #(
        .reset_vector (dut_reset_vector)
    ) branch_unit_top_inst (
        .clk        (clk),
        .reset      (reset),
        .clk_enable (clk_enable),
        .instruction(instr_word),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .fetch_pc   (fetch_pc),
        .link_write (link_write),
        .link_reg   (link_reg),
        .link_value (link_value)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //==========================================================================
    // stimulus
    //==========================================================================

    task automatic draw_bits(input int count, output logic [31:0] bits);
        bits = 32'd0;
        for (int i = 0; i < count; i++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic make_instruction(output logic [31:0] word);
        logic [31:0] group;
        logic [31:0] sel;
        logic [31:0] body;
        logic [4:0]  code;
        logic [5:0]  fn;
        draw_bits(2, group);
        draw_bits(32, body);
        word = body;
        case (group[1:0])
            2'd0: begin
                draw_bits(4, sel);
                case (sel % 32'd12)
                    0: word[31:26] = op_beq;
                    1: word[31:26] = op_bne;
                    2: word[31:26] = op_blez;
                    3: word[31:26] = op_bgtz;
                    4: word[31:16] = {op_regimm, body[25:21], rt_bltz};
                    5: word[31:16] = {op_regimm, body[25:21], rt_bgez};
                    6: word[31:16] = {op_regimm, body[25:21], rt_bltzal};
                    7: word[31:16] = {op_regimm, body[25:21], rt_bgezal};
                    8: word[31:26] = op_j;
                    9: word[31:26] = op_jal;
                    10: word = {op_special, body[25:6], funct_jr};
                    default: word = {op_special, body[25:6], funct_jalr};
                endcase
            end
            2'd1: begin
                if (body[31:26] < 6'd8) word[31:26] = body[31:26] + 6'd8;  // keep clear of control opcodes
            end
            2'd2: word = 32'd0;
            default: begin
                draw_bits(1, sel);
                code = body[20:16];
                fn   = body[5:0];
                if (code == rt_bltz || code == rt_bgez || code == rt_bltzal || code == rt_bgezal)
                    code = code ^ 5'b00100;
                if (fn == funct_jr || fn == funct_jalr)
                    fn = fn ^ 6'h10;
                if (sel[0]) word = {op_regimm, body[25:21], code, body[15:0]};
                else word = {op_special, body[25:6], fn};
            end
        endcase
    endtask

    task automatic make_operands(output logic [31:0] a, output logic [31:0] b);
        logic [31:0] mode;
        draw_bits(32, a);
        draw_bits(32, b);
        draw_bits(3, mode);
        case (mode[2:0])
            3'd0: b = a;                  // equal operands
            3'd1: a = 32'd0;
            3'd2: a[31] = 1'b1;           // negative rs
            3'd3: begin
                a = 32'd0;
                b = 32'd0;
            end
            default: a = a;
        endcase
    endtask

    task automatic finish_run();
        $display("error counts: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        logic [31:0] pick;
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        int          issued;
        lfsr_state = 32'heb40;
        reset      = 1'b1;
        clk_enable = 1'b0;
        instr_word = 32'd0;
        rs_value   = 32'd0;
        rt_value   = 32'd0;
        issued     = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (issued < num_instr) begin
            draw_bits(3, pick);
            clk_enable = (pick[2:0] != 3'd0);  // about one stalled edge in eight
            make_instruction(word);
            make_operands(a, b);
            instr_word = word;
            rs_value   = a;
            rt_value   = b;
            if (clk_enable) issued++;
            @(negedge clk);
        end
        clk_enable = 1'b1;
        instr_word = 32'd0;
        repeat (3) @(negedge clk);
        finish_run();
    end

    initial begin
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        timeout_count++;
        finish_run();
    end

    //==========================================================================
    // reference model, one enabled edge ahead of the checks
    //==========================================================================

    always @(posedge clk) begin
        if (reset) begin
            model_fetch_pc      <= dut_reset_vector;
            model_decode_pc     <= dut_reset_vector - 32'd4;
            exp_link_write      <= 1'b0;
            consumed_sequential <= 1'b0;
        end else begin
            exp_link_write      <= clk_enable && link_expected(instr_word);
            consumed_sequential <= clk_enable && !branch_taken(instr_word, rs_value, rt_value);
            if (clk_enable) begin
                model_decode_pc <= model_fetch_pc;
                model_fetch_pc  <= branch_taken(instr_word, rs_value, rt_value) ?
                                   branch_target(instr_word, rs_value, model_decode_pc) :
                                   model_fetch_pc + 32'd4;
                exp_link_reg    <= link_register(instr_word);
                exp_link_value  <= model_decode_pc + 32'd8;
            end
        end
    end

    //==========================================================================
    // checks
    //==========================================================================

    reset_state_check: assert property (
        @(posedge clk) disable iff (reset)
        $fell(reset) |-> (fetch_pc == dut_reset_vector && !link_write)
    ) else begin
        $display("mismatch at %0t: fetch_pc %h after reset", $time, $sampled(fetch_pc));
        mismatch_count++;
    end

    fetch_pc_check: assert property (
        @(posedge clk) disable iff (reset)
        fetch_pc == model_fetch_pc
    ) else begin
        $display("mismatch at %0t: fetch_pc %h, expected %h", $time,
                 $sampled(fetch_pc), $sampled(model_fetch_pc));
        mismatch_count++;
    end

    sequential_step_check: assert property (
        @(posedge clk) disable iff (reset)
        consumed_sequential |-> fetch_pc == $past(model_fetch_pc) + 32'd4
    ) else begin
        $display("mismatch at %0t: fetch_pc %h did not step by 4", $time, $sampled(fetch_pc));
        mismatch_count++;
    end

    link_write_check: assert property (
        @(posedge clk) disable iff (reset)
        link_write == exp_link_write
    ) else begin
        $display("mismatch at %0t: link_write %b, expected %b", $time,
                 $sampled(link_write), $sampled(exp_link_write));
        mismatch_count++;
    end

    link_data_check: assert property (
        @(posedge clk) disable iff (reset)
        exp_link_write |-> (link_reg == exp_link_reg && link_value == exp_link_value)
    ) else begin
        $display("mismatch at %0t: link r%0d = %h, expected r%0d = %h", $time,
                 $sampled(link_reg), $sampled(link_value),
                 $sampled(exp_link_reg), $sampled(exp_link_value));
        mismatch_count++;
    end

    stall_hold_check: assert property (
        @(posedge clk) disable iff (reset)
        !clk_enable |=> (fetch_pc == $past(model_fetch_pc) && !link_write && $stable(link_value))
    ) else begin
        $display("mismatch at %0t: state moved across a stalled edge", $time);
        mismatch_count++;
    end

endmodule

/* branch_unit_top.f */
+incdir+bench
logic/mips_branch_pkg.sv
logic/branch_decode.sv
logic/branch_resolve.sv
logic/pc_sequencer.sv
logic/branch_unit_top.sv
bench/branch_unit_tb.sv
